// ==== build.f ====
logic/sifhPkg.sv
logic/binMapper.sv
logic/histogramBuilder.sv
logic/peakDetector.sv
logic/zoomWindow.sv
logic/apbRegs.sv
logic/sifhTop.sv
dv/sifhTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the histogram engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module sifhTb -o sifhSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "compile step failed with status $status"
    exit 1
fi

./obj_dir/sifhSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the verdict
if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
exit 0

// ==== dv/sifhTb.sv ====
`timescale 1ns/1ps

module sifhTb;

    // one row of the scenario table, negative expectations mean model only
    typedef struct packed {
        int batch;
        int centre;
        int spread;
        int noise;
        bit twinOn;
        int twin;
        int expCoarse;
        int expCount;
    } scenario_t;

    logic             clk = 1'b0;
    logic             arstN;
    sifhPkg::apbReq_t apbReq;
    sifhPkg::apbRsp_t apbRsp;
    sifhPkg::event_t  evt;
    logic             eventReady;

    scenario_t                  rows [7];
    // arrival times of the current run, coarse batch first
    logic [sifhPkg::TIME_W-1:0] times [$];
    // cycle number of each accepted event
    int                         acceptCyc [$];
    int                         cycle = 0;
    int                         checks = 0;
    int                         errors = 0;
    bit                         timedOut = 1'b0;

    sifhTop sifhTop_inst (
        .clk        (clk),
        .arstN      (arstN),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .evt        (evt),
        .eventReady (eventReady)
    );

    // 20 ns period
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // handshake seen mid cycle is taken on the coming rising edge
    always @(negedge clk) begin
        if (evt.valid && eventReady) begin
            acceptCyc.push_back(cycle);
        end
    end

    task automatic checkValue(input string what, input int got, input int want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, want);
        end
    endtask

    // one apb transfer, entered and left 1 ns after a rising edge
    task automatic apbAccess(input logic write, input logic [3:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int waited;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #1;
        apbReq.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apbRsp.pready && waited < 16) begin
            waited++;
            @(negedge clk);
        end
        if (!apbRsp.pready) begin
            timedOut = 1'b1;
            errors++;
            $display("timeout: pready never rose at offset %0h", addr);
        end
        // access phase completes without wait states
        checkValue("apb wait states", waited, 0);
        // sample mid cycle, before the completing edge
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);
        #1;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
    endtask

    // clustered times around centre or twin, plus uniform noise
    task automatic makeEvents(input scenario_t row, input int total);
        int t;
        times.delete();
        for (int i = 0; i < total; i++) begin
            if (int'($urandom % 100) < row.noise) begin
                t = int'($urandom % 1024);
            end else begin
                t = (row.twinOn && (i % 2 == 1)) ? row.twin : row.centre;
                if (row.spread > 0) begin
                    t = t + int'($urandom % (2 * row.spread + 1)) - row.spread;
                end
                t = (t < 0) ? 0 : ((t > 1023) ? 1023 : t);
            end
            times.push_back(t[sifhPkg::TIME_W-1:0]);
        end
    endtask

    // highest count, earlier bin keeps a tie
    function automatic void peakOf(input int hist [sifhPkg::BINS],
                                   output int pBin, output int pCnt);
        pBin = 0;
        pCnt = hist[0];
        for (int b = 1; b < sifhPkg::BINS; b++) begin
            if (hist[b] > pCnt) begin
                pBin = b;
                pCnt = hist[b];
            end
        end
    endfunction

    // expected results straight from the binning and window rules
    task automatic runModel(input int eff, output int cBin, output int fBin,
                            output int fCnt, output int finalT);
        int hist [sifhPkg::BINS];
        int cCnt;
        int lo;
        int t;
        foreach (hist[b]) begin
            hist[b] = 0;
        end
        // coarse bins 32 ticks wide, counts stop at 255
        for (int i = 0; i < eff; i++) begin
            t = int'(times[i]);
            if (hist[t / 32] < 255) begin
                hist[t / 32]++;
            end
        end
        peakOf(hist, cBin, cCnt);
        // window lower edge, clamped into 0..992
        lo = cBin * 32 - 16;
        lo = (lo < 0) ? 0 : ((lo > 992) ? 992 : lo);
        foreach (hist[b]) begin
            hist[b] = 0;
        end
        // out-of-window events count toward the batch only
        for (int i = eff; i < 2 * eff; i++) begin
            t = int'(times[i]);
            if (t >= lo && t <= lo + 31 && hist[t - lo] < 255) begin
                hist[t - lo]++;
            end
        end
        peakOf(hist, fBin, fCnt);
        finalT = lo + fBin;
    endtask

    // holds each event until the DUT takes it
    task automatic feedEvents(input int total);
        int waited;
        for (int i = 0; i < total; i++) begin
            evt.valid   = 1'b1;
            evt.arrTime = times[i];
            waited = 0;
            @(negedge clk);
            while (!eventReady && waited < 100 && !timedOut) begin
                waited++;
                @(negedge clk);
            end
            if (!eventReady) begin
                timedOut = 1'b1;
                errors++;
                $display("timeout: event %0d of %0d was never accepted", i, total);
                break;
            end
            // ready is registered state, so the coming edge takes it
            @(posedge clk);
            #1;
        end
        evt.valid = 1'b0;
    endtask

    // polls STATUS until DONE, phases must only move forward
    task automatic watchPhases();
        logic [31:0] rd;
        logic        err;
        logic [2:0]  ph;
        logic [2:0]  last;
        bit          started;
        bit          restartSent;
        bit          scanC;
        bit          scanF;
        int          reads;
        last        = 3'd0;
        started     = 1'b0;
        restartSent = 1'b0;
        scanC       = 1'b0;
        scanF       = 1'b0;
        reads       = 0;
        while (!timedOut) begin
            apbAccess(1'b0, sifhPkg::ADDR_STATUS, 32'h0, rd, err);
            ph = rd[2:0];
            reads++;
            // old DONE may still show before the start lands
            if (ph != sifhPkg::IDLE && ph != sifhPkg::DONE) begin
                started = 1'b1;
            end
            if (started) begin
                checkValue("phase order", int'(ph >= last), 1);
                last = ph;
            end
            scanC = scanC || (ph == sifhPkg::COARSE_SCAN);
            scanF = scanF || (ph == sifhPkg::FINE_SCAN);
            // start mid run, must be dropped
            if (ph == sifhPkg::FINE && !restartSent) begin
                apbAccess(1'b1, sifhPkg::ADDR_CTRL, 32'h1, rd, err);
                restartSent = 1'b1;
            end
            if (started && ph == sifhPkg::DONE) begin
                break;
            end
            if (reads > 2000) begin
                timedOut = 1'b1;
                errors++;
                $display("timeout: STATUS never reached DONE");
            end
        end
        if (!timedOut) begin
            checkValue("coarse scan seen", int'(scanC), 1);
            checkValue("fine scan seen", int'(scanF), 1);
        end
    endtask

    task automatic checkRegisters();
        logic [31:0] rd;
        logic        err;
        apbAccess(1'b0, sifhPkg::ADDR_EVENTS, 32'h0, rd, err);
        checkValue("events reset value", int'(rd), 64);
        checkValue("pslverr on EVENTS", int'(err), 0);
        apbAccess(1'b0, sifhPkg::ADDR_STATUS, 32'h0, rd, err);
        checkValue("status reset value", int'(rd), 0);
        apbAccess(1'b0, sifhPkg::ADDR_RESULT, 32'h0, rd, err);
        checkValue("result reset value", int'(rd), 0);
        checkValue("ready after reset", int'(eventReady), 0);
        apbAccess(1'b1, sifhPkg::ADDR_EVENTS, 32'h0000_0123, rd, err);
        apbAccess(1'b0, sifhPkg::ADDR_EVENTS, 32'h0, rd, err);
        checkValue("events readback", int'(rd), 'h123);
        // offsets outside the map
        apbAccess(1'b0, 4'h2, 32'h0, rd, err);
        checkValue("pslverr on unmapped read", int'(err), 1);
        apbAccess(1'b1, 4'h6, 32'h1, rd, err);
        checkValue("pslverr on unmapped write", int'(err), 1);
    endtask

    task automatic runScenario(input scenario_t row);
        logic [31:0] rd;
        logic        err;
        int          eff;
        int          cBin;
        int          fBin;
        int          fCnt;
        int          finalT;
        // a zero batch runs as one event
        eff = (row.batch == 0) ? 1 : row.batch;
        makeEvents(row, 2 * eff);
        runModel(eff, cBin, fBin, fCnt, finalT);
        acceptCyc.delete();
        apbAccess(1'b1, sifhPkg::ADDR_EVENTS, 32'(row.batch), rd, err);
        fork
            feedEvents(2 * eff);
            begin
                apbAccess(1'b1, sifhPkg::ADDR_CTRL, 32'h1, rd, err);
                watchPhases();
            end
        join
        if (timedOut) begin
            return;
        end
        // event offered after DONE must be held
        evt.valid = 1'b1;
        repeat (5) begin
            @(negedge clk);
            checkValue("ready after done", int'(eventReady), 0);
        end
        @(posedge clk);
        #1;
        evt.valid = 1'b0;
        // both batches taken in full, nothing after DONE
        checkValue("events accepted", acceptCyc.size(), 2 * eff);
        if (acceptCyc.size() > eff) begin
            // last coarse to first fine acceptance
            checkValue("hand-over cycles", acceptCyc[eff] - acceptCyc[eff - 1],
                       sifhPkg::BINS + 2);
        end
        apbAccess(1'b0, sifhPkg::ADDR_STATUS, 32'h0, rd, err);
        checkValue("status after run", int'(rd), 8 + int'(sifhPkg::DONE));
        apbAccess(1'b0, sifhPkg::ADDR_RESULT, 32'h0, rd, err);
        checkValue("final time", int'(rd[9:0]), finalT);
        checkValue("coarse peak bin", int'(rd[14:10]), cBin);
        checkValue("fine peak bin", int'(rd[19:15]), fBin);
        checkValue("fine peak count", int'(rd[27:20]), fCnt);
        if (row.expCoarse >= 0) begin
            checkValue("coarse bin against table", int'(rd[14:10]), row.expCoarse);
        end
        if (row.expCount >= 0) begin
            checkValue("fine count against table", int'(rd[27:20]), row.expCount);
        end
    endtask

    initial begin
        void'($urandom(32'h464d4898));
        apbReq = '0;
        evt    = '0;
        arstN  = 1'b0;
        // batch, centre, spread, noise %, twin on, twin time, coarse bin, fine count
        rows[0] = '{64, 300, 10, 10, 1'b0, 0, 9, -1};
        // near 0, low clamp
        rows[1] = '{100, 5, 6, 0, 1'b0, 0, 0, -1};
        // near 1023, high end
        rows[2] = '{80, 1018, 4, 5, 1'b0, 0, 31, -1};
        // two equal clusters, bin 6 beats bin 21
        rows[3] = '{40, 200, 0, 0, 1'b1, 700, 6, 20};
        // 400 identical times saturate
        rows[4] = '{400, 517, 0, 0, 1'b0, 0, 16, 255};
        rows[5] = '{0, 640, 0, 0, 1'b0, 0, 20, 1};
        rows[6] = '{120, 450, 40, 30, 1'b0, 0, -1, -1};
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkRegisters();
        for (int r = 0; r < 7 && !timedOut; r++) begin
            runScenario(rows[r]);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/sifhTop.sv ====
`timescale 1ns/1ps

module sifhTop (
    input  logic             clk,
    input  logic             arstN,
    input  sifhPkg::apbReq_t apbReq,
    output sifhPkg::apbRsp_t apbRsp,
    input  sifhPkg::event_t  evt,
    output logic             eventReady
);

    // control and phase
    sifhPkg::runCtrl_t              runCtrl;
    sifhPkg::phase_t                phase;
    // event mapping
    sifhPkg::window_t               window;
    logic [sifhPkg::BIN_W-1:0]      bin;
    logic                           inWindow;
    // scan path to the peak search
    logic [sifhPkg::BIN_W-1:0]      scanIdx;
    logic [sifhPkg::COUNT_W-1:0]    scanCount;
    logic                           scanActive;
    sifhPkg::peakResult_t           peak;

    apbRegs apbRegs_inst (
        .clk     (clk),
        .arstN   (arstN),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .phase   (phase),
        .window  (window),
        .peak    (peak),
        .runCtrl (runCtrl)
    );

    binMapper binMapper_inst (
        .phase    (phase),
        .window   (window),
        .evt      (evt),
        .bin      (bin),
        .inWindow (inWindow)
    );

    histogramBuilder histogramBuilder_inst (
        .clk        (clk),
        .arstN      (arstN),
        .runCtrl    (runCtrl),
        .evt        (evt),
        .eventReady (eventReady),
        .bin        (bin),
        .inWindow   (inWindow),
        .peak       (peak),
        .phase      (phase),
        .scanIdx    (scanIdx),
        .scanCount  (scanCount),
        .scanActive (scanActive)
    );

    peakDetector peakDetector_inst (
        .clk        (clk),
        .arstN      (arstN),
        .scanActive (scanActive),
        .scanIdx    (scanIdx),
        .scanCount  (scanCount),
        .peak       (peak)
    );

    // same peak feeds the window, only the coarse scan captures it
    zoomWindow zoomWindow_inst (
        .clk        (clk),
        .arstN      (arstN),
        .coarsePeak (peak),
        .phase      (phase),
        .window     (window)
    );

endmodule

// ==== logic/apbRegs.sv ====
`timescale 1ns/1ps

module apbRegs (
    input  logic                 clk,
    input  logic                 arstN,
    input  sifhPkg::apbReq_t     apbReq,
    output sifhPkg::apbRsp_t     apbRsp,
    input  sifhPkg::phase_t      phase,
    input  sifhPkg::window_t     window,
    input  sifhPkg::peakResult_t peak,
    output sifhPkg::runCtrl_t    runCtrl
);

    logic                            access;
    logic                            wrEn;
    logic                            addrHit;
    logic                            startR;
    logic [sifhPkg::EVT_W-1:0]       eventsReg;
    logic [sifhPkg::BIN_W-1:0]       coarseBin;
    logic [sifhPkg::BIN_W-1:0]       fineBin;
    logic [sifhPkg::COUNT_W-1:0]     fineCount;
    logic [sifhPkg::TIME_W-1:0]      finalTime;
    logic [sifhPkg::DATA_W-1:0]      rdData;

    // access phase of an apb transfer
    assign access  = apbReq.psel && apbReq.penable;
    assign wrEn    = access && apbReq.pwrite;
    assign addrHit = apbReq.paddr inside {sifhPkg::ADDR_CTRL, sifhPkg::ADDR_EVENTS,
                                          sifhPkg::ADDR_STATUS, sifhPkg::ADDR_RESULT};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            startR    <= 1'b0;
            eventsReg <= sifhPkg::EVT_RESET;
            coarseBin <= '0;
            fineBin   <= '0;
            fineCount <= '0;
            finalTime <= '0;
        end else begin
            // start is a single cycle pulse
            startR <= wrEn && (apbReq.paddr == sifhPkg::ADDR_CTRL) && apbReq.pwdata[0];
            if (wrEn && (apbReq.paddr == sifhPkg::ADDR_EVENTS)) begin
                eventsReg <= apbReq.pwdata[sifhPkg::EVT_W-1:0];
            end
            // which pass a peak belongs to follows from the phase
            if (peak.valid && (phase == sifhPkg::COARSE_SCAN)) begin
                coarseBin <= peak.bin;
            end
            if (peak.valid && (phase == sifhPkg::FINE_SCAN)) begin
                fineBin   <= peak.bin;
                fineCount <= peak.count;
                // lower edge plus fine bin
                finalTime <= window.thMinus +
                             {{(sifhPkg::TIME_W - sifhPkg::BIN_W){1'b0}}, peak.bin};
            end
        end
    end

    // read mux, CTRL reads as zero
    always_comb begin
        case (apbReq.paddr)
            sifhPkg::ADDR_EVENTS: begin
                rdData = {{(sifhPkg::DATA_W - sifhPkg::EVT_W){1'b0}}, eventsReg};
            end
            sifhPkg::ADDR_STATUS: begin
                rdData = {{(sifhPkg::DATA_W - 4){1'b0}}, (phase == sifhPkg::DONE), phase};
            end
            sifhPkg::ADDR_RESULT: begin
                rdData = {4'b0000, fineCount, fineBin, coarseBin, finalTime};
            end
            default: begin
                rdData = '0;
            end
        endcase
    end

    // no wait states
    assign apbRsp.prdata  = rdData;
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access && !addrHit;

    assign runCtrl.start        = startR;
    assign runCtrl.eventsPerHis = eventsReg;

endmodule

// ==== logic/zoomWindow.sv ====
`timescale 1ns/1ps

module zoomWindow (
    input  logic                 clk,
    input  logic                 arstN,
    input  sifhPkg::peakResult_t coarsePeak,
    input  sifhPkg::phase_t      phase,
    output sifhPkg::window_t     window
);

    // start of the coarse peak bin in ticks
    logic [sifhPkg::TIME_W-1:0] centre;
    // lower edge after clamping
    logic [sifhPkg::TIME_W-1:0] lowNext;

    always_comb begin
        centre = {coarsePeak.bin, {(sifhPkg::TIME_W - sifhPkg::BIN_W){1'b0}}};
        // clamp low end at 0, high end so thPlus stays at 1023
        if (centre < sifhPkg::WIN_HALF) begin
            lowNext = '0;
        end else if ((centre - sifhPkg::WIN_HALF) > sifhPkg::WIN_MAX) begin
            lowNext = sifhPkg::WIN_MAX;
        end else begin
            lowNext = centre - sifhPkg::WIN_HALF;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            window.thMinus <= '0;
            window.thPlus  <= sifhPkg::WIN_SPAN;
        end else if ((phase == sifhPkg::COARSE_SCAN) && coarsePeak.valid) begin
            window.thMinus <= lowNext;
            window.thPlus  <= lowNext + sifhPkg::WIN_SPAN;
        end
    end

    // fixed width window, never wrapped past 1023
    assert property (@(posedge clk) disable iff (!arstN)
        ((window.thPlus - window.thMinus) == sifhPkg::WIN_SPAN) &&
        (window.thPlus > window.thMinus));

endmodule

// ==== logic/peakDetector.sv ====
`timescale 1ns/1ps

module peakDetector (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          scanActive,
    input  logic [sifhPkg::BIN_W-1:0]     scanIdx,
    input  logic [sifhPkg::COUNT_W-1:0]   scanCount,
    output sifhPkg::peakResult_t          peak
);

    // running maximum and where it was seen
    logic [sifhPkg::COUNT_W-1:0] maxCnt;
    logic [sifhPkg::BIN_W-1:0]   maxIdx;
    // result strobe, one cycle after the last bin
    logic                        validR;
    logic                        newMax;

    // first bin seeds, later bins need a strictly larger count
    assign newMax = (scanIdx == '0) || (scanCount > maxCnt);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            maxCnt <= '0;
            maxIdx <= '0;
            validR <= 1'b0;
        end else begin
            validR <= scanActive && (scanIdx == sifhPkg::LAST_BIN);
            if (scanActive && newMax) begin
                maxCnt <= scanCount;
                maxIdx <= scanIdx;
            end
        end
    end

    // result held until the next scan
    assign peak.bin   = maxIdx;
    assign peak.count = maxCnt;
    assign peak.valid = validR;

    // one strobe per scan
    assert property (@(posedge clk) disable iff (!arstN)
        peak.valid |=> !peak.valid);

endmodule

// ==== logic/histogramBuilder.sv ====
`timescale 1ns/1ps

module histogramBuilder (
    input  logic                          clk,
    input  logic                          arstN,
    input  sifhPkg::runCtrl_t             runCtrl,
    input  sifhPkg::event_t               evt,
    output logic                          eventReady,
    input  logic [sifhPkg::BIN_W-1:0]     bin,
    input  logic                          inWindow,
    input  sifhPkg::peakResult_t          peak,
    output sifhPkg::phase_t               phase,
    output logic [sifhPkg::BIN_W-1:0]     scanIdx,
    output logic [sifhPkg::COUNT_W-1:0]   scanCount,
    output logic                          scanActive
);

    // one saturating counter per bin
    logic [sifhPkg::COUNT_W-1:0] binCnt [sifhPkg::BINS];
    // events taken so far in the current pass
    logic [sifhPkg::EVT_W-1:0] evtCnt;
    // batch size latched at start, never zero
    logic [sifhPkg::EVT_W-1:0] batchSize;
    logic accept;
    logic lastEvt;

    // only the two acquisition phases take events
    assign eventReady = (phase == sifhPkg::COARSE) || (phase == sifhPkg::FINE);
    assign accept     = evt.valid && eventReady;
    assign lastEvt    = accept && (evtCnt == batchSize - 1'b1);
    // scan reads the bin before it is cleared on the same edge
    assign scanCount  = binCnt[scanIdx];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase      <= sifhPkg::IDLE;
            evtCnt     <= '0;
            batchSize  <= sifhPkg::EVT_W'(1);
            scanIdx    <= '0;
            scanActive <= 1'b0;
        end else begin
            case (phase)
                sifhPkg::IDLE, sifhPkg::DONE: begin
                    // a start elsewhere is dropped here
                    if (runCtrl.start) begin
                        phase     <= sifhPkg::COARSE;
                        evtCnt    <= '0;
                        batchSize <= (runCtrl.eventsPerHis == '0) ? sifhPkg::EVT_W'(1)
                                                                 : runCtrl.eventsPerHis;
                    end
                end
                sifhPkg::COARSE, sifhPkg::FINE: begin
                    if (lastEvt) begin
                        phase      <= (phase == sifhPkg::COARSE) ? sifhPkg::COARSE_SCAN
                                                                 : sifhPkg::FINE_SCAN;
                        evtCnt     <= '0;
                        scanIdx    <= '0;
                        scanActive <= 1'b1;
                    end else if (accept) begin
                        evtCnt <= evtCnt + 1'b1;
                    end
                end
                sifhPkg::COARSE_SCAN, sifhPkg::FINE_SCAN: begin
                    if (scanActive) begin
                        // walk all bins once
                        if (scanIdx == sifhPkg::LAST_BIN) begin
                            scanActive <= 1'b0;
                        end else begin
                            scanIdx <= scanIdx + 1'b1;
                        end
                    end else if (peak.valid) begin
                        // peak settled, move on
                        phase <= (phase == sifhPkg::COARSE_SCAN) ? sifhPkg::FINE
                                                                 : sifhPkg::DONE;
                    end
                end
                default: begin
                    phase <= sifhPkg::IDLE;
                end
            endcase
        end
    end

    // bin counters: clear under scan, else count in-window events
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < sifhPkg::BINS; i++) begin
                binCnt[i] <= '0;
            end
        end else if (scanActive) begin
            binCnt[scanIdx] <= '0;
        end else if (accept && inWindow && (binCnt[bin] != '1)) begin
            binCnt[bin] <= binCnt[bin] + 1'b1;
        end
    end

    // ready only while the batch is still open
    assert property (@(posedge clk) disable iff (!arstN)
        eventReady |-> ((phase inside {sifhPkg::COARSE, sifhPkg::FINE}) &&
                        !scanActive && (evtCnt < batchSize)));

    // a full counter holds until the scan clears it
    for (genvar g = 0; g < sifhPkg::BINS; g++) begin : gNoWrap
        assert property (@(posedge clk) disable iff (!arstN)
            (!scanActive && (binCnt[g] == '1)) |=> (binCnt[g] == '1));
    end

endmodule

// ==== logic/binMapper.sv ====
`timescale 1ns/1ps

module binMapper (
    input  sifhPkg::phase_t          phase,
    input  sifhPkg::window_t         window,
    input  sifhPkg::event_t          evt,
    output logic [sifhPkg::BIN_W-1:0] bin,
    output logic                     inWindow
);

    // offset of the event inside the zoom window
    logic [sifhPkg::TIME_W-1:0] fineOffset;

    always_comb begin
        // coarse mapping by default, top bits of the arrival time
        bin        = evt.arrTime[sifhPkg::TIME_W-1 -: sifhPkg::BIN_W];
        inWindow   = 1'b0;
        fineOffset = evt.arrTime - window.thMinus;
        case (phase)
            sifhPkg::COARSE: begin
                // every time lands in some coarse bin
                inWindow = 1'b1;
            end
            sifhPkg::FINE: begin
                // 1-tick bins relative to the lower edge
                bin = fineOffset[sifhPkg::BIN_W-1:0];
                // inclusive on both edges
                inWindow = (evt.arrTime >= window.thMinus) &&
                           (evt.arrTime <= window.thPlus);
            end
            default: begin
                // scan, idle and done phases bin nothing
                inWindow = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/sifhPkg.sv ====
package sifhPkg;

    // event time and histogram geometry
    localparam int TIME_W  = 10;
    localparam int BIN_W   = 5;
    localparam int BINS    = 32;
    localparam int COUNT_W = 8;
    localparam int EVT_W   = 16;

    // apb widths
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    // index of the final bin in a scan
    localparam logic [BIN_W-1:0] LAST_BIN = BIN_W'(BINS - 1);

    // batch size after reset
    localparam logic [EVT_W-1:0] EVT_RESET = EVT_W'(64);

    // zoom window: 32 ticks, centred half a coarse bin below the peak start
    localparam logic [TIME_W-1:0] WIN_HALF = TIME_W'(16);
    localparam logic [TIME_W-1:0] WIN_SPAN = TIME_W'(31);
    localparam logic [TIME_W-1:0] WIN_MAX  = TIME_W'(992);

    // register word offsets
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [ADDR_W-1:0] ADDR_EVENTS = 4'h4;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'h8;
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 4'hC;

    typedef enum logic [2:0] {
        IDLE,
        COARSE,
        COARSE_SCAN,
        FINE,
        FINE_SCAN,
        DONE
    } phase_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apbRsp_t;

    typedef struct packed {
        logic              valid;
        logic [TIME_W-1:0] arrTime;
    } event_t;

    typedef struct packed {
        logic [TIME_W-1:0] thMinus;
        logic [TIME_W-1:0] thPlus;
    } window_t;

    typedef struct packed {
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
        logic               valid;
    } peakResult_t;

    typedef struct packed {
        logic             start;
        logic [EVT_W-1:0] eventsPerHis;
    } runCtrl_t;

endpackage
